/* sim.f */
verilog/rv_isa_pkg.sv
verilog/rv_mach_pkg.sv
verilog/rv_regfile.sv
verilog/rv_alu.sv
verilog/rv_csr_file.sv
verilog/rv_exec_ctrl.sv
verilog/riscv64_core.sv
test/tb_riscv64.sv

/* test/tb_riscv64.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_riscv64 import rv_isa_pkg::*, rv_mach_pkg::*; ();

    localparam logic [ILEN-1:0] NOP = 32'h0000_0013;      // addi x0, x0, 0
    localparam logic [XLEN-1:0] M5  = 64'hFFFF_FFFF_FFFF_FFFB;  // -5

    logic            clk;
    logic            reset;
    logic [ILEN-1:0] instr;
    logic [XLEN-1:0] pc;
    logic            irq_req;
    logic            irq_ack;
    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    logic [ILEN-1:0] prog [128];  // Program ROM from RESET_PC
    int              n;           // Next ROM slot
    logic [XLEN-1:0] chk_at [$];  // Checkpoint fetch address
    int              chk_reg [$];
    logic [XLEN-1:0] chk_exp [$];
    logic [31:0]     lfsr = 32'hef7e;
    int              errors = 0;
    int              timeouts = 0;

    riscv64_core i_riscv64_core (
        .clk, .reset,
        .instr_i (instr), .pc_o (pc),
        .irq_req_i (irq_req), .irq_ack_o (irq_ack),
        .regs_o (regs)
    );

    always #4 clk = ~clk;

    // Same-cycle fetch with unmapped addresses reading as nop
    always_comb begin
        logic [XLEN-1:0] off;
        off = pc - RESET_PC;
        if (off < 512 && off[1:0] == 2'b00) instr = prog[off[8:2]];
        else instr = NOP;
    end

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [XLEN-1:0] addr_of(int idx);
        return RESET_PC + XLEN'(idx * 4);
    endfunction

    function automatic logic [XLEN-1:0] sext32(logic [31:0] w);
        return {{32{w[31]}}, w};
    endfunction

    // Hand encoders per format
    function automatic logic [31:0] i_type(int imm, int rs1, int f3, int rd, logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] r_type(int f7, int rs2, int rs1, int f3, int rd,
                                           logic [6:0] op);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] b_type(int off, int rs2, int rs1, int f3);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] j_type(int off, int rd);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OP_JAL};
    endfunction

    function automatic logic [31:0] u_type(int imm, int rd, logic [6:0] op);
        return {imm[19:0], rd[4:0], op};
    endfunction

    task automatic emit(logic [31:0] w);
        prog[n] = w;
        n++;
    endtask

    // Skipped instr bumps x4 on the wrong path and x3 on fall-through
    task automatic branch_pair(int f3, int rs1, int rs2, bit taken);
        emit(b_type(8, rs2, rs1, f3));
        emit(taken ? i_type(1, 4, 0, 4, OP_IMM) : i_type(1, 3, 0, 3, OP_IMM));
    endtask

    task automatic add_check(int at, int rd, logic [XLEN-1:0] exp);
        chk_at.push_back(addr_of(at));
        chk_reg.push_back(rd);
        chk_exp.push_back(exp);
    endtask

    task automatic check_xlen(logic [XLEN-1:0] got, logic [XLEN-1:0] exp, string what);
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(logic got, logic exp, string what);
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic wait_pc(logic [XLEN-1:0] target, int max_cycles);
        int cnt;
        cnt = 0;
        while (pc !== target && cnt < max_cycles) begin
            @(negedge clk);
            cnt++;
        end
        if (pc !== target) begin
            timeouts++;
            $display("Timeout: fetch address never reached %h", target);
        end
    endtask

    task automatic wait_ack(logic level, int max_cycles);
        int cnt;
        cnt = 0;
        while (irq_ack !== level && cnt < max_cycles) begin
            @(negedge clk);
            cnt++;
        end
        if (irq_ack !== level) begin
            timeouts++;
            $display("Timeout: interrupt acknowledge did not go to %b", level);
        end
    endtask

    initial begin
        int delay;
        clk     = 1'b0;
        reset   = 1'b0;
        irq_req = 1'b0;
        for (int i = 0; i < 128; i++) prog[i] = NOP;
        n = 0;
        // Immediate ALU forms
        emit(i_type(-5, 0, 0, 1, OP_IMM));
        emit(i_type(12, 0, 0, 2, OP_IMM));
        emit(i_type(12'h0F0, 1, 4, 3, OP_IMM));    // xori
        emit(i_type(12'h100, 1, 6, 4, OP_IMM));    // ori
        emit(i_type(12'h0FF, 1, 7, 5, OP_IMM));    // andi
        emit(i_type(1, 1, 2, 6, OP_IMM));          // slti
        emit(i_type(1, 1, 3, 7, OP_IMM));          // sltiu
        emit(i_type(36, 1, 1, 8, OP_IMM));         // slli
        emit(i_type(60, 1, 5, 9, OP_IMM));         // srli
        emit(i_type(12'h404, 1, 5, 10, OP_IMM));   // srai
        // Register forms
        emit(r_type(0, 2, 1, 0, 11, OP_REG));
        emit(r_type(7'h20, 2, 1, 0, 12, OP_REG));  // sub
        emit(r_type(0, 2, 2, 1, 13, OP_REG));
        emit(r_type(0, 2, 1, 5, 14, OP_REG));
        emit(r_type(7'h20, 2, 1, 5, 15, OP_REG));  // sra
        emit(r_type(0, 2, 1, 2, 16, OP_REG));
        emit(r_type(0, 2, 1, 3, 17, OP_REG));
        // Word forms on bit 31 set
        emit(u_type(20'h80000, 18, OP_LUI));
        emit(i_type(1, 18, 0, 19, OP_IMM_W));
        emit(i_type(28, 2, 1, 20, OP_IMM_W));
        emit(i_type(4, 18, 5, 21, OP_IMM_W));
        emit(i_type(12'h404, 18, 5, 22, OP_IMM_W));
        emit(r_type(0, 1, 18, 0, 23, OP_REG_W));
        emit(r_type(7'h20, 18, 2, 0, 24, OP_REG_W));
        emit(r_type(0, 2, 1, 1, 25, OP_REG_W));
        emit(r_type(0, 2, 18, 5, 26, OP_REG_W));
        emit(r_type(7'h20, 2, 18, 5, 27, OP_REG_W));
        emit(u_type(1, 28, OP_AUIPC));             // idx 27
        emit(NOP);
        // Branches from idx 29
        emit(i_type(0, 0, 0, 3, OP_IMM));
        emit(i_type(0, 0, 0, 4, OP_IMM));
        branch_pair(0, 2, 2, 1);
        branch_pair(1, 1, 2, 1);
        branch_pair(4, 1, 2, 1);
        branch_pair(5, 2, 1, 1);
        branch_pair(6, 2, 1, 1);
        branch_pair(7, 1, 2, 1);
        branch_pair(0, 1, 2, 0);
        branch_pair(1, 2, 2, 0);
        branch_pair(4, 2, 1, 0);
        branch_pair(5, 1, 2, 0);
        branch_pair(6, 1, 2, 0);
        branch_pair(7, 2, 1, 0);
        emit(j_type(8, 5));                        // idx 55
        emit(i_type(1, 4, 0, 4, OP_IMM));
        emit(u_type(0, 6, OP_AUIPC));              // idx 57
        emit(i_type(16, 6, 0, 7, OP_JALR));        // to idx 61
        emit(i_type(1, 4, 0, 4, OP_IMM));
        emit(i_type(1, 4, 0, 4, OP_IMM));
        // mscratch read-modify-write from idx 61
        emit(i_type(12'h05A, 0, 0, 8, OP_IMM));
        emit(i_type(CSR_MSCRATCH, 8, 1, 9, OP_SYSTEM));   // csrrw
        emit(i_type(12'h00F, 0, 0, 10, OP_IMM));
        emit(i_type(CSR_MSCRATCH, 10, 2, 11, OP_SYSTEM)); // csrrs
        emit(i_type(CSR_MSCRATCH, 3, 7, 12, OP_SYSTEM));  // csrrci
        emit(i_type(CSR_MSCRATCH, 1, 6, 13, OP_SYSTEM));  // csrrsi
        emit(i_type(CSR_MSCRATCH, 10, 3, 14, OP_SYSTEM)); // csrrc
        emit(i_type(CSR_MSCRATCH, 7, 5, 15, OP_SYSTEM));  // csrrwi
        emit(i_type(CSR_MSCRATCH, 0, 2, 16, OP_SYSTEM));  // Read only
        emit(NOP);
        // Trap setup and counting loop from idx 71
        emit(u_type(0, 17, OP_AUIPC));
        emit(i_type(100, 17, 0, 17, OP_IMM));      // Handler at idx 96
        emit(i_type(CSR_MTVEC, 17, 1, 0, OP_SYSTEM));
        emit(i_type(0, 0, 0, 18, OP_IMM));
        emit(i_type(40, 0, 0, 19, OP_IMM));
        emit(i_type(0, 0, 0, 20, OP_IMM));
        emit(i_type(0, 0, 0, 21, OP_IMM));
        emit(i_type(0, 0, 0, 22, OP_IMM));
        emit(i_type(1, 18, 0, 18, OP_IMM));        // Loop top at idx 79
        emit(b_type(-4, 19, 18, 1));
        emit(NOP);
        emit(j_type(0, 0));                        // Final self-loop at idx 82
        n = 96;
        emit(i_type(CSR_MCAUSE, 0, 2, 20, OP_SYSTEM));
        emit(i_type(CSR_MEPC, 0, 2, 21, OP_SYSTEM));
        emit(i_type(1, 22, 0, 22, OP_IMM));
        emit(MRET_WORD);

        // Expected values grouped by checkpoint
        add_check(29, 1, M5);
        add_check(29, 2, 64'd12);
        add_check(29, 3, M5 ^ 64'h0F0);
        add_check(29, 4, M5 | 64'h100);
        add_check(29, 5, M5 & 64'h0FF);
        add_check(29, 6, 64'd1);
        add_check(29, 7, 64'd0);
        add_check(29, 8, M5 << 36);
        add_check(29, 9, M5 >> 60);
        add_check(29, 10, 64'($signed(M5) >>> 4));
        add_check(29, 11, M5 + 64'd12);
        add_check(29, 12, M5 - 64'd12);
        add_check(29, 13, 64'd12 << 12);
        add_check(29, 14, M5 >> 12);
        add_check(29, 15, 64'($signed(M5) >>> 12));
        add_check(29, 16, 64'd1);
        add_check(29, 17, 64'd0);
        add_check(29, 18, sext32(32'h8000_0000));
        add_check(29, 19, sext32(32'h8000_0001));
        add_check(29, 20, sext32(32'd12 << 28));
        add_check(29, 21, 64'(32'h8000_0000 >> 4));
        add_check(29, 22, sext32(32'($signed(32'h8000_0000) >>> 4)));
        add_check(29, 23, sext32(32'h8000_0000 + 32'hFFFF_FFFB));
        add_check(29, 24, sext32(32'd12 - 32'h8000_0000));
        add_check(29, 25, sext32(32'hFFFF_FFFB << 12));
        add_check(29, 26, 64'(32'h8000_0000 >> 12));
        add_check(29, 27, sext32(32'($signed(32'h8000_0000) >>> 12)));
        add_check(29, 28, addr_of(27) + 64'h1000);
        add_check(71, 3, 64'd6);                   // All not-taken fell through
        add_check(71, 4, 64'd0);                   // No wrong-path write
        add_check(71, 5, addr_of(56));
        add_check(71, 7, addr_of(59));
        add_check(71, 9, 64'd0);
        add_check(71, 11, 64'h5A);
        add_check(71, 12, 64'h5A | 64'h0F);
        add_check(71, 13, (64'h5A | 64'h0F) & ~64'h3);
        add_check(71, 14, ((64'h5A | 64'h0F) & ~64'h3) | 64'h1);
        add_check(71, 15, (((64'h5A | 64'h0F) & ~64'h3) | 64'h1) & ~64'h0F);
        add_check(71, 16, 64'd7);
        add_check(82, 18, 64'd40);                 // Loop resumed after MRET
        add_check(82, 20, MCAUSE_MEI);
        add_check(82, 22, 64'd1);                  // Handler ran once

        @(negedge clk);
        check_xlen(pc, RESET_PC, "pc in reset");
        check_bit(irq_ack, 1'b0, "irq_ack_o in reset");
        repeat (5) @(posedge clk);
        reset <= 1'b1;
        @(negedge clk);
        check_xlen(pc, RESET_PC, "pc after reset");
        check_bit(irq_ack, 1'b0, "irq_ack_o after reset");

        fork
            begin
                for (int i = 0; i < chk_reg.size(); i++) begin
                    if (i == 0 || chk_at[i] != chk_at[i-1]) wait_pc(chk_at[i], 400);
                    check_xlen(regs[chk_reg[i]], chk_exp[i], $sformatf("x%0d", chk_reg[i]));
                end
                check_bit(regs[21] == addr_of(79) || regs[21] == addr_of(80), 1'b1,
                          "mepc inside loop");
            end
            begin
                wait_pc(addr_of(79), 400);
                delay = 0;
                for (int b = 0; b < 4; b++) begin
                    delay = (delay << 1) | lfsr[0];
                    lfsr  = lfsr_next(lfsr);
                end
                repeat (4 + delay) @(posedge clk);
                irq_req <= 1'b1;
                wait_ack(1'b1, 50);
                repeat (3) begin                   // Ack stays up while req is held
                    @(negedge clk);
                    check_bit(irq_ack, 1'b1, "irq_ack_o while req held");
                end
                @(posedge clk);
                irq_req <= 1'b0;
                @(negedge clk);
                wait_ack(1'b0, 50);
            end
        join

        $display("Errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/riscv64_core.sv */
`timescale 1ns/1ns
`default_nettype none

module riscv64_core import rv_isa_pkg::*, rv_mach_pkg::*; (
    input  wire               clk,
    input  wire               reset,
    input  wire  [ILEN-1:0]   instr_i,   // Returned same cycle as pc_o
    output logic [XLEN-1:0]   pc_o,
    input  wire               irq_req_i,
    output logic              irq_ack_o,
    output logic [XLEN-1:0]   regs_o [2**REG_ADDR_W]
);

    logic [REG_ADDR_W-1:0] rs1_addr, rs2_addr, rd_addr;
    logic [XLEN-1:0]       rs1_data, rs2_data, rd_data;
    logic                  rd_we;
    logic [ALU_OP_W-1:0]   alu_op;
    logic [XLEN-1:0]       op_a, op_b, alu_result;
    logic                  word, branch_taken;
    logic [F3_W-1:0]       funct3;
    logic [CSR_OP_W-1:0]   csr_op;
    logic [CSR_ADDR_W-1:0] csr_addr;
    logic [XLEN-1:0]       csr_operand, csr_rdata;
    logic                  exec_valid, mret, irq_take;
    logic [XLEN-1:0]       exec_pc, mtvec, mepc;

    rv_regfile i_rv_regfile (
        .clk, .reset,
        .rs1_addr_i (rs1_addr), .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data), .rs2_data_o (rs2_data),
        .we_i (rd_we), .rd_addr_i (rd_addr), .rd_data_i (rd_data),
        .regs_o
    );

    rv_alu i_rv_alu (
        .op_a_i (op_a), .op_b_i (op_b), .alu_op_i (alu_op),
        .word_i (word), .funct3_i (funct3),
        .result_o (alu_result), .branch_taken_o (branch_taken)
    );

    rv_csr_file i_rv_csr_file (
        .clk, .reset,
        .csr_op_i (csr_op), .csr_addr_i (csr_addr), .csr_operand_i (csr_operand),
        .csr_rdata_o (csr_rdata),
        .exec_valid_i (exec_valid), .exec_pc_i (exec_pc), .mret_i (mret),
        .irq_req_i, .irq_ack_o, .irq_take_o (irq_take),
        .mtvec_o (mtvec), .mepc_o (mepc)
    );

    rv_exec_ctrl i_rv_exec_ctrl (
        .clk, .reset, .instr_i, .pc_o,
        .rs1_addr_o (rs1_addr), .rs2_addr_o (rs2_addr),
        .rs1_data_i (rs1_data), .rs2_data_i (rs2_data),
        .rd_we_o (rd_we), .rd_addr_o (rd_addr), .rd_data_o (rd_data),
        .alu_op_o (alu_op), .op_a_o (op_a), .op_b_o (op_b),
        .word_o (word), .funct3_o (funct3),
        .alu_result_i (alu_result), .branch_taken_i (branch_taken),
        .csr_op_o (csr_op), .csr_addr_o (csr_addr), .csr_operand_o (csr_operand),
        .csr_rdata_i (csr_rdata),
        .exec_valid_o (exec_valid), .exec_pc_o (exec_pc), .mret_o (mret),
        .irq_take_i (irq_take), .mtvec_i (mtvec), .mepc_i (mepc)
    );

endmodule

`default_nettype wire

/* verilog/rv_alu.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_alu import rv_isa_pkg::*; (
    input  wire  [XLEN-1:0]     op_a_i,
    input  wire  [XLEN-1:0]     op_b_i,
    input  wire  [ALU_OP_W-1:0] alu_op_i,
    input  wire                 word_i,      // 32-bit word form
    input  wire  [F3_W-1:0]     funct3_i,    // Branch condition
    output logic [XLEN-1:0]     result_o,
    output logic                branch_taken_o
);

    logic [SHAMT_W-1:0] shamt;
    logic [4:0]         shamt_w;
    logic [31:0]        a_w;
    logic [31:0]        b_w;
    logic [XLEN-1:0]    res_d;  // Doubleword result
    logic [31:0]        res_w;  // Word result before sign extension

    assign shamt   = op_b_i[SHAMT_W-1:0];
    assign shamt_w = op_b_i[4:0];
    assign a_w     = op_a_i[31:0];
    assign b_w     = op_b_i[31:0];

    always_comb begin
        res_d = '0;
        res_w = '0;
        case (alu_op_i)
            ALU_ADD:  begin res_d = op_a_i + op_b_i;                  res_w = a_w + b_w; end
            ALU_SUB:  begin res_d = op_a_i - op_b_i;                  res_w = a_w - b_w; end
            ALU_SLL:  begin res_d = op_a_i << shamt;                  res_w = a_w << shamt_w; end
            ALU_SRL:  begin res_d = op_a_i >> shamt;                  res_w = a_w >> shamt_w; end
            ALU_SRA:  begin res_d = $signed(op_a_i) >>> shamt;        res_w = $signed(a_w) >>> shamt_w; end
            ALU_XOR:  res_d = op_a_i ^ op_b_i;
            ALU_OR:   res_d = op_a_i | op_b_i;
            ALU_AND:  res_d = op_a_i & op_b_i;
            ALU_SLT:  res_d = XLEN'($signed(op_a_i) < $signed(op_b_i));
            ALU_SLTU: res_d = XLEN'(op_a_i < op_b_i);
            default:  res_d = '0;
        endcase
    end

    // Word forms sign-extend bit 31
    assign result_o = word_i ? {{(XLEN-32){res_w[31]}}, res_w} : res_d;

    // Branch compare, independent of alu_op_i
    always_comb begin
        case (funct3_i)
            3'b000:  branch_taken_o = (op_a_i == op_b_i);                  // beq
            3'b001:  branch_taken_o = (op_a_i != op_b_i);                  // bne
            3'b100:  branch_taken_o = ($signed(op_a_i) < $signed(op_b_i));  // blt
            3'b101:  branch_taken_o = ($signed(op_a_i) >= $signed(op_b_i)); // bge
            3'b110:  branch_taken_o = (op_a_i < op_b_i);                   // bltu
            3'b111:  branch_taken_o = (op_a_i >= op_b_i);                  // bgeu
            default: branch_taken_o = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/rv_csr_file.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_csr_file import rv_isa_pkg::*, rv_mach_pkg::*; (
    input  wire                   clk,
    input  wire                   reset,
    input  wire  [CSR_OP_W-1:0]   csr_op_i,
    input  wire  [CSR_ADDR_W-1:0] csr_addr_i,
    input  wire  [XLEN-1:0]       csr_operand_i,
    output logic [XLEN-1:0]       csr_rdata_o,
    input  wire                   exec_valid_i,  // Execute holds a real instruction
    input  wire  [XLEN-1:0]       exec_pc_i,
    input  wire                   mret_i,
    input  wire                   irq_req_i,
    output logic                  irq_ack_o,
    output logic                  irq_take_o,
    output logic [XLEN-1:0]       mtvec_o,
    output logic [XLEN-1:0]       mepc_o
);

    logic [XLEN-1:0] mstatus;
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mscratch;
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] mcause;
    logic [XLEN-1:0] wdata;

    // New request only, with MIE set and something to interrupt
    assign irq_take_o = irq_req_i & ~irq_ack_o & mstatus[MSTATUS_MIE] & exec_valid_i;

    always_comb begin
        case (csr_addr_i)
            CSR_MSTATUS:  csr_rdata_o = mstatus;
            CSR_MTVEC:    csr_rdata_o = mtvec;
            CSR_MSCRATCH: csr_rdata_o = mscratch;
            CSR_MEPC:     csr_rdata_o = mepc;
            CSR_MCAUSE:   csr_rdata_o = mcause;
            default:      csr_rdata_o = '0;  // Unimplemented reads zero
        endcase
    end

    // Read-modify-write value
    always_comb begin
        case (csr_op_i)
            CSR_SET:   wdata = csr_rdata_o | csr_operand_i;
            CSR_CLEAR: wdata = csr_rdata_o & ~csr_operand_i;
            default:   wdata = csr_operand_i;
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            mstatus              <= '0;
            mstatus[MSTATUS_MIE] <= 1'b1;  // Interrupts on out of reset
            mtvec                <= '0;
            mscratch             <= '0;
            mepc                 <= '0;
            mcause               <= '0;
            irq_ack_o            <= 1'b0;
        end else begin
            irq_ack_o <= irq_take_o | (irq_ack_o & irq_req_i);  // Hold until req drops
            if (irq_take_o) begin
                mepc                  <= exec_pc_i;  // Discarded instruction reruns
                mcause                <= MCAUSE_MEI;
                mstatus[MSTATUS_MPIE] <= mstatus[MSTATUS_MIE];
                mstatus[MSTATUS_MIE]  <= 1'b0;
            end else if (mret_i) begin
                mstatus[MSTATUS_MIE]  <= mstatus[MSTATUS_MPIE];
                mstatus[MSTATUS_MPIE] <= 1'b1;
            end else if (csr_op_i != CSR_NONE) begin
                case (csr_addr_i)
                    CSR_MSTATUS:  mstatus  <= wdata;
                    CSR_MTVEC:    mtvec    <= wdata;
                    CSR_MSCRATCH: mscratch <= wdata;
                    CSR_MEPC:     mepc     <= wdata;
                    CSR_MCAUSE:   mcause   <= wdata;
                    default: ;
                endcase
            end
        end
    end

    assign mtvec_o = mtvec;
    assign mepc_o  = mepc;

endmodule

`default_nettype wire

/* verilog/rv_exec_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_exec_ctrl import rv_isa_pkg::*, rv_mach_pkg::*; (
    input  wire                   clk,
    input  wire                   reset,
    input  wire  [ILEN-1:0]       instr_i,
    output logic [XLEN-1:0]       pc_o,          // Fetch address
    output logic [REG_ADDR_W-1:0] rs1_addr_o,
    output logic [REG_ADDR_W-1:0] rs2_addr_o,
    input  wire  [XLEN-1:0]       rs1_data_i,
    input  wire  [XLEN-1:0]       rs2_data_i,
    output logic                  rd_we_o,
    output logic [REG_ADDR_W-1:0] rd_addr_o,
    output logic [XLEN-1:0]       rd_data_o,
    output logic [ALU_OP_W-1:0]   alu_op_o,
    output logic [XLEN-1:0]       op_a_o,
    output logic [XLEN-1:0]       op_b_o,
    output logic                  word_o,
    output logic [F3_W-1:0]       funct3_o,
    input  wire  [XLEN-1:0]       alu_result_i,
    input  wire                   branch_taken_i,
    output logic [CSR_OP_W-1:0]   csr_op_o,
    output logic [CSR_ADDR_W-1:0] csr_addr_o,
    output logic [XLEN-1:0]       csr_operand_o,
    input  wire  [XLEN-1:0]       csr_rdata_i,
    output logic                  exec_valid_o,
    output logic [XLEN-1:0]       exec_pc_o,
    output logic                  mret_o,
    input  wire                   irq_take_i,
    input  wire  [XLEN-1:0]       mtvec_i,
    input  wire  [XLEN-1:0]       mepc_i
);

    rv_instr_u       ir;
    logic            bubble;    // Squash the wrong-path fetch
    logic            redirect;
    logic [XLEN-1:0] next_pc;
    logic [XLEN-1:0] imm_i, imm_b, imm_j, imm_u, zimm;
    logic [6:0]      opcode;
    logic [F3_W-1:0] funct3;
    logic            is_lui, is_auipc, is_jal, is_jalr, is_branch;
    logic            is_imm, is_reg, is_csr, is_mret, sub_sra;

    assign opcode = ir.r_fmt.opcode;
    assign funct3 = ir.r_fmt.funct3;

    // Immediates per format
    assign imm_i = {{(XLEN-12){ir.i_fmt.imm12[11]}}, ir.i_fmt.imm12};
    assign imm_b = {{(XLEN-12){ir.b_fmt.imm12}}, ir.b_fmt.imm11, ir.b_fmt.imm10_5,
                    ir.b_fmt.imm4_1, 1'b0};
    assign imm_j = {{(XLEN-20){ir.j_fmt.imm20}}, ir.j_fmt.imm19_12, ir.j_fmt.imm11,
                    ir.j_fmt.imm10_1, 1'b0};
    assign imm_u = {{(XLEN-32){ir.u_fmt.imm20[19]}}, ir.u_fmt.imm20, 12'b0};
    assign zimm  = {{(XLEN-REG_ADDR_W){1'b0}}, ir.r_fmt.rs1};  // CSR immediate forms

    assign is_lui    = (opcode == OP_LUI);
    assign is_auipc  = (opcode == OP_AUIPC);
    assign is_jal    = (opcode == OP_JAL);
    assign is_jalr   = (opcode == OP_JALR);
    assign is_branch = (opcode == OP_BRANCH);
    assign is_imm    = (opcode == OP_IMM) || (opcode == OP_IMM_W);
    assign is_reg    = (opcode == OP_REG) || (opcode == OP_REG_W);
    assign is_csr    = (opcode == OP_SYSTEM) && (funct3 != '0);
    assign is_mret   = (ir.raw == MRET_WORD);
    assign word_o    = (opcode == OP_IMM_W) || (opcode == OP_REG_W);
    assign sub_sra   = (ir.r_fmt.funct7[6:1] == F7_SUB_SRA[6:1]);  // Bit 25 is shamt[5] on imm

    assign exec_valid_o = ~bubble;
    assign exec_pc_o    = pc_o - 4;  // Address of the instruction in ir
    assign mret_o       = exec_valid_o & is_mret;

    assign rs1_addr_o = ir.r_fmt.rs1;
    assign rs2_addr_o = ir.r_fmt.rs2;
    assign funct3_o   = funct3;

    // ALU operands, also jalr target and auipc sum
    assign op_a_o = is_auipc ? exec_pc_o : rs1_data_i;
    assign op_b_o = (is_reg || is_branch) ? rs2_data_i : (is_auipc ? imm_u : imm_i);

    always_comb begin
        alu_op_o = ALU_ADD;
        if (is_imm || is_reg) begin
            case (funct3)
                3'b000:  alu_op_o = (is_reg && sub_sra) ? ALU_SUB : ALU_ADD;
                3'b001:  alu_op_o = ALU_SLL;
                3'b010:  alu_op_o = ALU_SLT;
                3'b011:  alu_op_o = ALU_SLTU;
                3'b100:  alu_op_o = ALU_XOR;
                3'b101:  alu_op_o = sub_sra ? ALU_SRA : ALU_SRL;
                3'b110:  alu_op_o = ALU_OR;
                default: alu_op_o = ALU_AND;
            endcase
        end
    end

    // CSR access, set/clear with zero source is read only
    assign csr_addr_o    = ir.i_fmt.imm12;
    assign csr_operand_o = funct3[2] ? zimm : rs1_data_i;
    assign csr_op_o      = (exec_valid_o && is_csr && !(funct3[1] && ir.r_fmt.rs1 == '0)) ?
                           funct3[1:0] : CSR_NONE;

    // Writeback select
    assign rd_addr_o = ir.r_fmt.rd;
    assign rd_data_o = is_lui             ? imm_u :
                       (is_jal || is_jalr) ? pc_o :  // Link is exec_pc + 4
                       is_csr             ? csr_rdata_i : alu_result_i;
    assign rd_we_o   = exec_valid_o && !irq_take_i && (rd_addr_o != '0) &&
                       (is_lui || is_auipc || is_jal || is_jalr || is_imm || is_reg || is_csr);

    // Next PC, trap first
    always_comb begin
        next_pc  = pc_o + 4;
        redirect = 1'b0;
        if (irq_take_i) begin
            next_pc  = mtvec_i;
            redirect = 1'b1;
        end else if (exec_valid_o) begin
            redirect = 1'b1;
            if (is_mret)                        next_pc = mepc_i;
            else if (is_jal)                    next_pc = exec_pc_o + imm_j;
            else if (is_jalr)                   next_pc = {alu_result_i[XLEN-1:1], 1'b0};
            else if (is_branch && branch_taken_i) next_pc = exec_pc_o + imm_b;
            else                                redirect = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc_o   <= RESET_PC;
            ir     <= {25'b0, OP_IMM};  // addi x0, x0, 0
            bubble <= 1'b0;
        end else begin
            pc_o   <= next_pc;
            ir     <= instr_i;
            bubble <= redirect;
        end
    end

endmodule

`default_nettype wire

/* verilog/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    localparam int XLEN       = 64;
    localparam int ILEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int SHAMT_W    = 6;    // Word forms use low 5 bits
    localparam int F3_W       = 3;
    localparam int ALU_OP_W   = 4;

    // Major opcodes
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_IMM_W  = 7'b0011011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_REG_W  = 7'b0111011;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    localparam logic [6:0]      F7_SUB_SRA = 7'b0100000;
    localparam logic [ILEN-1:0] MRET_WORD  = 32'h3020_0073;

    // ALU operation codes
    localparam logic [ALU_OP_W-1:0] ALU_ADD  = 4'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB  = 4'd1;
    localparam logic [ALU_OP_W-1:0] ALU_XOR  = 4'd2;
    localparam logic [ALU_OP_W-1:0] ALU_OR   = 4'd3;
    localparam logic [ALU_OP_W-1:0] ALU_AND  = 4'd4;
    localparam logic [ALU_OP_W-1:0] ALU_SLL  = 4'd5;
    localparam logic [ALU_OP_W-1:0] ALU_SRL  = 4'd6;
    localparam logic [ALU_OP_W-1:0] ALU_SRA  = 4'd7;
    localparam logic [ALU_OP_W-1:0] ALU_SLT  = 4'd8;
    localparam logic [ALU_OP_W-1:0] ALU_SLTU = 4'd9;

    // One instruction word, several decode views
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_fmt;
        struct packed {
            logic       imm12;    // Sign bit
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b_fmt;
        struct packed {
            logic       imm20;    // Sign bit
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j_fmt;
        struct packed {
            logic [19:0] imm20;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u_fmt;
        logic [31:0] raw;
    } rv_instr_u;

endpackage

`default_nettype wire

/* verilog/rv_mach_pkg.sv */
`default_nettype none

package rv_mach_pkg;

    localparam int CSR_ADDR_W = 12;

    // Machine CSR addresses
    localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS  = 12'h300;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC    = 12'h305;
    localparam logic [CSR_ADDR_W-1:0] CSR_MSCRATCH = 12'h340;
    localparam logic [CSR_ADDR_W-1:0] CSR_MEPC     = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE   = 12'h342;

    // mstatus bits
    localparam int MSTATUS_MIE  = 3;
    localparam int MSTATUS_MPIE = 7;

    localparam logic [63:0] MCAUSE_MEI = 64'h8000_0000_0000_000B;  // Interrupt, cause 11
    localparam logic [63:0] RESET_PC   = 64'h8000_0000;

    // CSR ops, same order as funct3[1:0]
    localparam int CSR_OP_W = 2;
    localparam logic [CSR_OP_W-1:0] CSR_NONE  = 2'd0;
    localparam logic [CSR_OP_W-1:0] CSR_WRITE = 2'd1;
    localparam logic [CSR_OP_W-1:0] CSR_SET   = 2'd2;
    localparam logic [CSR_OP_W-1:0] CSR_CLEAR = 2'd3;

endpackage

`default_nettype wire

/* verilog/rv_regfile.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_regfile import rv_isa_pkg::*; (
    input  wire                   clk,
    input  wire                   reset,
    input  wire  [REG_ADDR_W-1:0] rs1_addr_i,
    input  wire  [REG_ADDR_W-1:0] rs2_addr_i,
    output logic [XLEN-1:0]       rs1_data_o,
    output logic [XLEN-1:0]       rs2_data_o,
    input  wire                   we_i,
    input  wire  [REG_ADDR_W-1:0] rd_addr_i,
    input  wire  [XLEN-1:0]       rd_data_i,
    output logic [XLEN-1:0]       regs_o [2**REG_ADDR_W]
);

    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_addr_i != '0) begin  // x0 never written
            regs[rd_addr_i] <= rd_data_i;
        end
    end

    assign rs1_data_o = regs[rs1_addr_i];  // Combinational read
    assign rs2_data_o = regs[rs2_addr_i];
    assign regs_o     = regs;              // Debug view

endmodule

`default_nettype wire
